// File: list.f
+incdir+verif
source/cpu_ctrl_pkg.sv
source/instr_decode.sv
source/mode_sequencer.sv
source/cpu_control_top.sv
verif/tb_cpu_control.sv

// File: verif/cpu_control_model.svh
`ifndef CPU_CONTROL_MODEL_SVH
`define CPU_CONTROL_MODEL_SVH

// Expected control word for one beat
function automatic cpu_ctrl_pkg::ctrl_word_t model_ctrl(
    input logic [2:0] sw,
    input logic [3:0] ir,
    input logic       c,
    input logic       z,
    input logic [3:1] w,
    input logic       st0
);
    cpu_ctrl_pkg::ctrl_word_t k;
    k = '0;
    if (sw == 3'b001 || sw == 3'b010) begin
        // Both memory modes act on w1 only
        k.stop       = w[1];
        k.short_beat = w[1];
        k.selctl     = w[1];
        k.arinc      = w[1] && st0;
        k.lar        = w[1] && !st0;
        k.sbus       = w[1] && (sw == 3'b001 || !st0);
        k.memw       = w[1] && st0 && sw == 3'b001;
        k.mbus       = w[1] && st0 && sw == 3'b010;
    end else if (sw == 3'b011) begin
        k.selctl = w[1] || w[2];
        k.stop   = w[1] || w[2];
        k.sel    = w[2] ? 4'b1011 : {3'b000, w[1]};
    end else if (sw == 3'b100) begin
        k.sbus   = w[1] || w[2];
        k.selctl = w[1] || w[2];
        k.drw    = w[1] || w[2];
        k.stop   = w[1] || w[2];
        // First pass writes R0 then R1, second pass R2 then R3
        case ({st0, w[2], w[1]})
            3'b001:  k.sel = 4'b0011;
            3'b010:  k.sel = 4'b0100;
            3'b101:  k.sel = 4'b1001;
            3'b110:  k.sel = 4'b1110;
            default: k.sel = {st0, 3'b000};
        endcase
    end else if (sw == 3'b000 && !st0) begin
        k.lpc        = w[1];
        k.sbus       = w[1];
        k.short_beat = w[1];
        k.stop       = w[1];
    end else if (sw == 3'b000) begin
        k.lir   = w[1];
        k.pcinc = w[1];
        if (ir inside {4'b0001, 4'b0010, 4'b0011, 4'b0100, 4'b1100, 4'b1101}) begin
            k.abus = w[2];
            k.drw  = w[2];
            k.ldz  = w[2];
            k.ldc  = w[2] && (ir inside {4'b0001, 4'b0010, 4'b0100});
            k.m    = w[2] && (ir inside {4'b0011, 4'b1100, 4'b1101});
        end
        k.cin = w[2] && ir == 4'b0001;
        case (ir)
            4'b0001: k.s = 4'b1001;
            4'b0010: k.s = 4'b0110;
            4'b0011: k.s = 4'b1011;
            4'b0101: k.s = 4'b1010;
            4'b0110: k.s = w[2] ? 4'b1111 : 4'b1010;
            4'b1001: k.s = 4'b1111;
            4'b1010: k.s = 4'b1010;
            4'b1100: k.s = 4'b1110;
            4'b1101: k.s = 4'b0110;
            default: k.s = 4'b0000;
        endcase
        if (ir inside {4'b0101, 4'b0110, 4'b1001, 4'b1010}) begin
            k.m    = w[2] || (w[3] && ir == 4'b0110);
            k.abus = w[2] || (w[3] && ir == 4'b0110);
        end
        k.lar       = w[2] && (ir inside {4'b0101, 4'b0110});
        k.long_beat = w[2] && (ir inside {4'b0101, 4'b0110});
        k.mbus      = w[3] && ir == 4'b0101;
        k.memw      = w[3] && ir == 4'b0110;
        k.lpc       = w[2] && ir == 4'b1001;
        k.stop      = w[2] && ir == 4'b1110;
        k.pcadd     = w[2] && ((ir == 4'b0111 && c) || (ir == 4'b1000 && z));
        if (ir == 4'b0101) begin
            k.drw = w[3];
        end
    end
    return k;
endfunction

// Phase bit after the next falling edge
function automatic logic model_next_st0(
    input logic       rst,
    input logic [2:0] sw,
    input logic [3:1] w,
    input logic       st0
);
    logic set;
    set = (sw == 3'b001 && w[1]) || (sw == 3'b010 && w[1] && !st0)
        || (sw == 3'b100 && w[2] && !st0) || (sw == 3'b000 && w[1] && !st0);
    if (rst)
        return 1'b0;
    if (set)
        return 1'b1;
    if (sw == 3'b100 && st0 && w[2])
        return 1'b0;
    return st0;
endfunction

`endif

// File: verif/tb_cpu_control.sv
`timescale 1ns/1ns

module tb_cpu_control;
    import cpu_ctrl_pkg::*;

    `include "cpu_control_model.svh"

    // Cycles per test, resets included
    localparam int RESET_TEST_CYCLES = 4;
    localparam int MEM_TEST_CYCLES   = 44;
    localparam int REG_TEST_CYCLES   = 42;
    localparam int EXEC_TEST_CYCLES  = 603;
    localparam int MIXED_TEST_CYCLES = 1200;
    localparam int MAX_CYCLES = RESET_TEST_CYCLES + MEM_TEST_CYCLES + REG_TEST_CYCLES
        + EXEC_TEST_CYCLES + MIXED_TEST_CYCLES + 100;

    logic      t3;
    logic      rst;
    logic      c;
    logic      z;
    mode_t     sw;
    opcode_t   ir;
    beat_t     w;
    logic      ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd, arinc;
    logic      selctl, memw, stop, lir, sbus, mbus, short_beat, long_beat;
    alu_func_t s;
    sel_t      sel;

    int          cycle_count;
    int          check_count;
    int          error_count;
    int          st0_clears;
    logic        model_st0;
    logic        last_st0;
    logic [31:0] lfsr;

    cpu_control_top UUT (
        .t3 (t3), .rst (rst), .c (c), .z (z), .sw (sw), .ir (ir), .w (w),
        .ldc (ldc), .ldz (ldz), .cin (cin), .s (s), .sel (sel), .m (m),
        .abus (abus), .drw (drw), .pcinc (pcinc), .lpc (lpc), .lar (lar),
        .pcadd (pcadd), .arinc (arinc), .selctl (selctl), .memw (memw),
        .stop (stop), .lir (lir), .sbus (sbus), .mbus (mbus),
        .short_beat (short_beat), .long_beat (long_beat)
    );

    always #2 t3 = ~t3;

    function automatic logic [31:0] lfsr_step(input logic [31:0] st);
        return st[0] ? ((st >> 1) ^ 32'hD000_0001) : (st >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic draw_beat(output beat_t wv);
        logic [31:0] b;
        take_bits(2, b);
        wv = (b[1:0] == 2'd0) ? 3'b000 : 3'b001 << (b[1:0] - 2'd1); // none, w1, w2 or w3
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_outputs();
        ctrl_word_t k;
        k = model_ctrl(sw, ir, c, z, w, model_st0);
        check_value("st0", UUT.u_mode_sequencer.st0, model_st0);
        check_value("ldc", ldc, k.ldc);
        check_value("ldz", ldz, k.ldz);
        check_value("cin", cin, k.cin);
        check_value("s", s, k.s);
        check_value("sel", sel, k.sel);
        check_value("m", m, k.m);
        check_value("abus", abus, k.abus);
        check_value("drw", drw, k.drw);
        check_value("pcinc", pcinc, k.pcinc);
        check_value("lpc", lpc, k.lpc);
        check_value("lar", lar, k.lar);
        check_value("pcadd", pcadd, k.pcadd);
        check_value("arinc", arinc, k.arinc);
        check_value("selctl", selctl, k.selctl);
        check_value("memw", memw, k.memw);
        check_value("stop", stop, k.stop);
        check_value("lir", lir, k.lir);
        check_value("sbus", sbus, k.sbus);
        check_value("mbus", mbus, k.mbus);
        check_value("short_beat", short_beat, k.short_beat);
        check_value("long_beat", long_beat, k.long_beat);
    endtask

    // Outputs are read at the falling edge, before st0 moves
    task automatic drive_cycle(input logic rst_v, input mode_t sw_v, input opcode_t ir_v,
                               input logic c_v, input logic z_v, input beat_t w_v);
        logic dut_st0;
        @(posedge t3);
        #1;
        rst = rst_v;
        sw  = sw_v;
        ir  = ir_v;
        c   = c_v;
        z   = z_v;
        w   = w_v;
        @(negedge t3);
        dut_st0 = UUT.u_mode_sequencer.st0;
        if (!rst) begin
            compare_outputs();
            if (sw == MODE_WRITE_REG && last_st0 && !dut_st0) begin
                st0_clears++; // Cleared by the previous w2
            end
        end
        last_st0  = dut_st0;
        model_st0 = model_next_st0(rst, sw, w, model_st0);
    endtask

    task automatic random_cycle(input logic any_mode, input mode_t mode);
        logic [31:0] b;
        mode_t       sv;
        opcode_t     iv;
        logic        cv;
        logic        zv;
        beat_t       wv;
        sv = mode;
        if (any_mode) begin
            take_bits(3, b);
            sv = b[2:0]; // Unused codes included
        end
        take_bits(4, b);
        iv = b[3:0];
        take_bits(1, b);
        cv = b[0];
        take_bits(1, b);
        zv = b[0];
        draw_beat(wv);
        drive_cycle(1'b0, sv, iv, cv, zv, wv);
    endtask

    task automatic apply_reset();
        repeat (2) drive_cycle(1'b1, MODE_RUN, 4'h0, 1'b0, 1'b0, 3'b000);
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        $display("Test %0d %s done, %0d errors", num, name, error_count - errs_before);
    endtask

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge t3);
            cycle_count++;
        end
        $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int errs;
        int i;
        t3          = 1'b0;
        rst         = 1'b1;
        sw          = MODE_RUN;
        ir          = 4'h0;
        c           = 1'b0;
        z           = 1'b0;
        w           = 3'b000;
        lfsr        = 32'h9b32_6573;
        model_st0   = 1'b0;
        last_st0    = 1'b0;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        st0_clears  = 0;

        errs = error_count;
        apply_reset();
        drive_cycle(1'b0, MODE_RUN, 4'h0, 1'b0, 1'b0, 3'b000); // All idle
        drive_cycle(1'b0, MODE_RUN, 4'h0, 1'b0, 1'b0, 3'b001); // PC-load beat
        finish_test(1, "reset", errs);

        errs = error_count;
        apply_reset();
        repeat (20) random_cycle(1'b0, MODE_WRITE_MEM);
        apply_reset();
        repeat (20) random_cycle(1'b0, MODE_READ_MEM);
        finish_test(2, "console memory modes", errs);

        errs = error_count;
        apply_reset();
        repeat (20) random_cycle(1'b0, MODE_READ_REG);
        // w1, w2, idle, so each pair of w2 sets then clears st0
        for (i = 0; i < 20; i++) begin
            drive_cycle(1'b0, MODE_WRITE_REG, 4'h0, 1'b0, 1'b0,
                        (i % 3 == 2) ? 3'b000 : ((i % 3 == 0) ? 3'b001 : 3'b010));
        end
        if (st0_clears == 0) begin
            error_count++;
            $display("The write-register sequence never brought st0 back to 0");
        end
        finish_test(3, "console register modes", errs);

        errs = error_count;
        apply_reset();
        drive_cycle(1'b0, MODE_RUN, 4'h0, 1'b0, 1'b0, 3'b001);
        #1;
        if (UUT.u_mode_sequencer.st0 !== 1'b1) begin
            error_count++;
            $display("The run start-up beat did not move into the fetch phase");
        end
        repeat (600) random_cycle(1'b0, MODE_RUN);
        finish_test(4, "instruction execution", errs);

        errs = error_count;
        repeat (1200) random_cycle(1'b1, MODE_RUN);
        finish_test(5, "mixed random", errs);

        $display("Checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycle_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: source/cpu_control_top.sv
`timescale 1ns/1ns

module cpu_control_top (
    input  logic                    t3,
    input  logic                    rst,
    input  logic                    c,
    input  logic                    z,
    input  cpu_ctrl_pkg::mode_t     sw,
    input  cpu_ctrl_pkg::opcode_t   ir,
    input  cpu_ctrl_pkg::beat_t     w,
    output logic                    ldc,
    output logic                    ldz,
    output logic                    cin,
    output cpu_ctrl_pkg::alu_func_t s,
    output cpu_ctrl_pkg::sel_t      sel,
    output logic                    m,
    output logic                    abus,
    output logic                    drw,
    output logic                    pcinc,
    output logic                    lpc,
    output logic                    lar,
    output logic                    pcadd,
    output logic                    arinc,
    output logic                    selctl,
    output logic                    memw,
    output logic                    stop,
    output logic                    lir,
    output logic                    sbus,
    output logic                    mbus,
    output logic                    short_beat,
    output logic                    long_beat
);
    import cpu_ctrl_pkg::*;

    ctrl_word_t ctrl;

    mode_sequencer u_mode_sequencer (
        .t3   (t3),
        .rst  (rst),
        .sw   (sw),
        .ir   (ir),
        .c    (c),
        .z    (z),
        .w    (w),
        .ctrl (ctrl)
    );

    assign ldc        = ctrl.ldc;
    assign ldz        = ctrl.ldz;
    assign cin        = ctrl.cin;
    assign s          = ctrl.s;
    assign sel        = ctrl.sel;
    assign m          = ctrl.m;
    assign abus       = ctrl.abus;
    assign drw        = ctrl.drw;
    assign pcinc      = ctrl.pcinc;
    assign lpc        = ctrl.lpc;
    assign lar        = ctrl.lar;
    assign pcadd      = ctrl.pcadd;
    assign arinc      = ctrl.arinc;
    assign selctl     = ctrl.selctl;
    assign memw       = ctrl.memw;
    assign stop       = ctrl.stop;
    assign lir        = ctrl.lir;
    assign sbus       = ctrl.sbus;
    assign mbus       = ctrl.mbus;
    assign short_beat = ctrl.short_beat;
    assign long_beat  = ctrl.long_beat;

endmodule

// File: source/mode_sequencer.sv
`timescale 1ns/1ns

module mode_sequencer (
    input  logic                     t3,
    input  logic                     rst,
    input  cpu_ctrl_pkg::mode_t      sw,
    input  cpu_ctrl_pkg::opcode_t    ir,
    input  logic                     c,
    input  logic                     z,
    input  cpu_ctrl_pkg::beat_t      w,
    output cpu_ctrl_pkg::ctrl_word_t ctrl
);
    import cpu_ctrl_pkg::*;

    logic       st0;
    logic       sst0;
    ctrl_word_t instr_word;

    instr_decode u_instr_decode (
        .ir         (ir),
        .c          (c),
        .z          (z),
        .w          (w),
        .instr_word (instr_word)
    );

    // Phase bit, falling edge of t3
    always_ff @(negedge t3) begin
        if (rst) begin
            st0 <= 1'b0;
        end else if (sst0) begin
            st0 <= 1'b1;
        end else if (sw == MODE_WRITE_REG && st0 && w[2]) begin
            st0 <= 1'b0; // Second register pair written
        end
    end

    always_comb begin
        ctrl = CTRL_IDLE;
        sst0 = 1'b0;

        case (sw)
            MODE_WRITE_MEM: begin
                ctrl.lar        = w[1] && !st0; // First beat loads address
                ctrl.memw       = w[1] && st0;
                ctrl.arinc      = w[1] && st0;
                ctrl.sbus       = w[1];
                ctrl.stop       = w[1];
                ctrl.short_beat = w[1];
                ctrl.selctl     = w[1];
                sst0            = w[1];
            end
            MODE_READ_MEM: begin
                ctrl.sbus       = w[1] && !st0;
                ctrl.lar        = w[1] && !st0;
                ctrl.mbus       = w[1] && st0;
                ctrl.arinc      = w[1] && st0;
                ctrl.stop       = w[1];
                ctrl.short_beat = w[1];
                ctrl.selctl     = w[1];
                sst0            = w[1] && !st0;
            end
            MODE_READ_REG: begin
                // R0,R1 on w1 then R2,R3 on w2
                ctrl.selctl = w[1] || w[2];
                ctrl.stop   = w[1] || w[2];
                ctrl.sel    = {w[2], 1'b0, w[2], w[1] || w[2]};
            end
            MODE_WRITE_REG: begin
                ctrl.sbus   = w[1] || w[2];
                ctrl.selctl = w[1] || w[2];
                ctrl.drw    = w[1] || w[2];
                ctrl.stop   = w[1] || w[2];
                ctrl.sel    = {st0, w[2], (!st0 && w[1]) || (st0 && w[2]), w[1]};
                sst0        = w[2] && !st0;
            end
            MODE_RUN: begin
                if (!st0) begin
                    // Start-up beat loads PC from switches
                    ctrl.lpc        = w[1];
                    ctrl.sbus       = w[1];
                    ctrl.short_beat = w[1];
                    ctrl.stop       = w[1];
                    sst0            = w[1];
                end else begin
                    ctrl = instr_word;
                end
            end
            default: begin
                ctrl = CTRL_IDLE; // Unused switch codes
            end
        endcase
    end

    // Timing generator gives at most one beat at a time
    w_onehot_a: assert property (@(negedge t3) disable iff (rst) $onehot0(w))
        else $error("w is not one-hot: %b", w);

    // Address load and memory write from console or ST must not overlap
    lar_memw_a: assert property (@(negedge t3) disable iff (rst) !(ctrl.lar && ctrl.memw))
        else $error("lar and memw both active");

    memw_drw_a: assert property (@(negedge t3) disable iff (rst) !(ctrl.memw && ctrl.drw))
        else $error("memw and drw both active");

endmodule

// File: source/instr_decode.sv
`timescale 1ns/1ns

module instr_decode (
    input  cpu_ctrl_pkg::opcode_t    ir,
    input  logic                     c,
    input  logic                     z,
    input  cpu_ctrl_pkg::beat_t      w,
    output cpu_ctrl_pkg::ctrl_word_t instr_word
);
    import cpu_ctrl_pkg::*;

    always_comb begin
        instr_word       = CTRL_IDLE;
        instr_word.s     = ALU_PASS_A;
        // Fetch beat, common to all opcodes
        instr_word.lir   = w[1];
        instr_word.pcinc = w[1];

        case (ir)
            OP_ADD: begin
                instr_word.s    = ALU_ADD;
                instr_word.cin  = w[2];
                instr_word.abus = w[2];
                instr_word.drw  = w[2];
                instr_word.ldz  = w[2];
                instr_word.ldc  = w[2];
            end
            OP_SUB: begin
                instr_word.s    = ALU_SUB;
                instr_word.abus = w[2];
                instr_word.drw  = w[2];
                instr_word.ldz  = w[2];
                instr_word.ldc  = w[2];
            end
            OP_AND: begin
                instr_word.m    = w[2];
                instr_word.s    = ALU_AND;
                instr_word.abus = w[2];
                instr_word.drw  = w[2];
                instr_word.ldz  = w[2];
            end
            OP_INC: begin
                instr_word.s    = ALU_PASS_A;
                instr_word.abus = w[2];
                instr_word.drw  = w[2];
                instr_word.ldz  = w[2];
                instr_word.ldc  = w[2];
            end
            OP_LD: begin
                instr_word.m         = w[2];
                instr_word.s         = ALU_PASS_B;
                instr_word.abus      = w[2]; // Address from Rs
                instr_word.lar       = w[2];
                instr_word.long_beat = w[2];
                instr_word.drw       = w[3];
                instr_word.mbus      = w[3];
            end
            OP_ST: begin
                instr_word.m         = w[2] || w[3];
                instr_word.s         = w[2] ? ALU_ONES : ALU_PASS_B;
                instr_word.abus      = w[2] || w[3];
                instr_word.lar       = w[2];
                instr_word.long_beat = w[2];
                instr_word.memw      = w[3];
            end
            OP_JC: begin
                instr_word.pcadd = w[2] && c;
            end
            OP_JZ: begin
                instr_word.pcadd = w[2] && z;
            end
            OP_JMP: begin
                instr_word.m    = w[2];
                instr_word.s    = ALU_ONES;
                instr_word.abus = w[2];
                instr_word.lpc  = w[2];
            end
            OP_OUT: begin
                instr_word.m    = w[2];
                instr_word.s    = ALU_PASS_B;
                instr_word.abus = w[2];
            end
            OP_IRET: begin
                instr_word.s = ALU_PASS_A; // Plain fetch
            end
            OP_OR: begin
                instr_word.m    = w[2];
                instr_word.s    = ALU_OR;
                instr_word.abus = w[2];
                instr_word.drw  = w[2];
                instr_word.ldz  = w[2];
            end
            OP_XOR: begin
                // SUB code with m set gives XOR
                instr_word.m    = w[2];
                instr_word.s    = ALU_SUB;
                instr_word.abus = w[2];
                instr_word.drw  = w[2];
                instr_word.ldz  = w[2];
            end
            OP_STP: begin
                instr_word.stop = w[2];
            end
            default: begin
                instr_word.s = ALU_PASS_A;
            end
        endcase
    end

endmodule

// File: source/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // Console switch setting
    typedef logic [2:0] mode_t;

    localparam mode_t MODE_RUN       = 3'b000;
    localparam mode_t MODE_WRITE_MEM = 3'b001;
    localparam mode_t MODE_READ_MEM  = 3'b010;
    localparam mode_t MODE_READ_REG  = 3'b011;
    localparam mode_t MODE_WRITE_REG = 3'b100;

    // Upper nibble of IR
    typedef logic [3:0] opcode_t;

    localparam opcode_t OP_ADD  = 4'b0001;
    localparam opcode_t OP_SUB  = 4'b0010;
    localparam opcode_t OP_AND  = 4'b0011;
    localparam opcode_t OP_INC  = 4'b0100;
    localparam opcode_t OP_LD   = 4'b0101;
    localparam opcode_t OP_ST   = 4'b0110;
    localparam opcode_t OP_JC   = 4'b0111;
    localparam opcode_t OP_JZ   = 4'b1000;
    localparam opcode_t OP_JMP  = 4'b1001;
    localparam opcode_t OP_OUT  = 4'b1010;
    localparam opcode_t OP_IRET = 4'b1011; // No interrupts, fetch only
    localparam opcode_t OP_OR   = 4'b1100;
    localparam opcode_t OP_XOR  = 4'b1101;
    localparam opcode_t OP_STP  = 4'b1110;

    // ALU function select S
    typedef logic [3:0] alu_func_t;

    localparam alu_func_t ALU_ADD    = 4'b1001;
    localparam alu_func_t ALU_SUB    = 4'b0110; // XOR when m is set
    localparam alu_func_t ALU_AND    = 4'b1011;
    localparam alu_func_t ALU_PASS_A = 4'b0000;
    localparam alu_func_t ALU_PASS_B = 4'b1010;
    localparam alu_func_t ALU_OR     = 4'b1110;
    localparam alu_func_t ALU_ONES   = 4'b1111;

    // Machine beats, one-hot or idle
    typedef logic [3:1] beat_t;

    typedef logic [3:0] sel_t;

    typedef struct packed {
        logic      ldc;
        logic      ldz;
        logic      cin;
        logic      m;
        logic      abus;
        logic      drw;
        logic      pcinc;
        logic      lpc;
        logic      lar;
        logic      pcadd;
        logic      arinc;
        logic      selctl;
        logic      memw;
        logic      stop;
        logic      lir;
        logic      sbus;
        logic      mbus;
        logic      short_beat;
        logic      long_beat;
        alu_func_t s;
        sel_t      sel;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = '0;

endpackage
